// File: common/recon_defines.svh
// Geometry and quantizer limits of the luma reconstruction loop
// RECON_RASTER_IDX assumes square subblocks tiling a square macroblock
`ifndef RECON_DEFINES_SVH
`define RECON_DEFINES_SVH

`define RECON_MB_DIM      16
`define RECON_SB_DIM      4
`define RECON_SUBBLOCKS   16
`define RECON_QFIX        17
`define RECON_MAX_LEVEL   2047
`define RECON_RUN_STEPS   19

// Raster position of pixel p (raster inside the subblock) of subblock k
`define RECON_RASTER_IDX(k, p) \
    ((((k) / (`RECON_MB_DIM / `RECON_SB_DIM)) * `RECON_SB_DIM + (p) / `RECON_SB_DIM) \
     * `RECON_MB_DIM \
     + ((k) % (`RECON_MB_DIM / `RECON_SB_DIM)) * `RECON_SB_DIM + (p) % `RECON_SB_DIM)

`endif

// File: common/pixelPkg.sv
// Pixel, residual and level types of one 16x16 luma macroblock
// Macroblock pixels are raster ordered, macroblock levels subblock ordered
`default_nettype none

package pixelPkg;

    typedef logic        [7:0]  pixelT;
    typedef logic signed [8:0]  residualT;
    typedef logic signed [15:0] levelT;
    typedef logic        [3:0]  sbIndexT;

    // One 4x4 subblock, raster order inside the subblock
    typedef pixelT [15:0] sbPixelsT;
    typedef levelT [15:0] sbLevelsT;

    // Whole macroblock
    typedef pixelT [255:0] mbPixelsT;
    typedef levelT [255:0] mbLevelsT;

endpackage

`default_nettype wire

// File: common/quantPkg.sv
// Scalar quantizer values, one set for the whole macroblock
// iq is the reciprocal step in 17-bit fixed point
`default_nettype none

package quantPkg;

    typedef logic [15:0] qStepT;
    typedef logic [17:0] iqStepT;
    typedef logic [31:0] biasT;
    typedef logic [15:0] zthreshT;

endpackage

`default_nettype wire

// File: rtl/reconSequencer.sv
// Run FSM: start is taken only while idle or done
// done holds from the end of a run until the next accepted start
`timescale 1ns/100ps
`default_nettype none

module reconSequencer (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  start,
    input  wire  lastStep,
    output logic stepEnable,
    output logic stepClear,
    output logic done
);
    typedef enum logic [1:0] {IDLE, RUN, DONE} stateT;

    stateT state;
    stateT stateNext;
    logic  accept;

    assign accept     = start && (state != RUN);
    assign stepClear  = accept;
    assign stepEnable = (state == RUN);

    always_comb begin
        stateNext = state;
        case (state)
            IDLE, DONE: if (start) stateNext = RUN;
            RUN:        if (lastStep) stateNext = DONE;
            default:    stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            state <= stateNext;
            if (accept) begin
                done <= 1'b0;
            end else if (state == RUN && lastStep) begin
                done <= 1'b1;
            end
        end
    end

    noDoneInRun: assert property (@(posedge clk) disable iff (!rst_n)
        (state == RUN) |-> !done);

    // Counter must only reach its end while a run is active
    lastStepInRun: assert property (@(posedge clk) disable iff (!rst_n)
        lastStep |-> (state == RUN));

endmodule

`default_nettype wire

// File: rtl/stepCounter.sv
// Step counter of a run, parked at RECON_RUN_STEPS while idle
// so that the fetch stage sees no subblock outside a run
`timescale 1ns/100ps
`default_nettype none
`include "recon_defines.svh"

module stepCounter (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        stepEnable,
    input  wire        stepClear,
    output logic [4:0] step,
    output logic       lastStep
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step <= 5'(`RECON_RUN_STEPS);
        end else if (stepClear) begin
            step <= '0;
        end else if (stepEnable) begin
            step <= step + 5'd1;
        end
    end

    assign lastStep = (step == 5'(`RECON_RUN_STEPS - 1));

endmodule

`default_nettype wire

// File: rtl/subblockFetch.sv
// Gathers subblock number step from the raster macroblock
// Only steps below RECON_SUBBLOCKS produce a valid subblock
`timescale 1ns/100ps
`default_nettype none
`include "recon_defines.svh"

module subblockFetch (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [4:0]               step,
    input  wire pixelPkg::mbPixelsT ySrc,
    input  wire pixelPkg::mbPixelsT yPred,
    output pixelPkg::sbPixelsT      srcBlock,
    output pixelPkg::sbPixelsT      predBlock,
    output pixelPkg::sbIndexT       fetchIndex,
    output logic                    fetchValid
);
    import pixelPkg::*;

    localparam int SB_PIX = `RECON_SB_DIM * `RECON_SB_DIM;

    sbPixelsT srcGather;
    sbPixelsT predGather;

    // Four rows of four pixels, row stride of one macroblock line
    always_comb begin
        for (int p = 0; p < SB_PIX; p++) begin
            srcGather[p]  = ySrc[`RECON_RASTER_IDX(step[3:0], p)];
            predGather[p] = yPred[`RECON_RASTER_IDX(step[3:0], p)];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= (step < 5'(`RECON_SUBBLOCKS));
        end
    end

    always_ff @(posedge clk) begin
        srcBlock   <= srcGather;
        predBlock  <= predGather;
        fetchIndex <= step[3:0];
    end

endmodule

`default_nettype wire

// File: quant/residualQuantizer.sv
// Quantizes the residual of one subblock per cycle, all 16 pixels in parallel
// Levels are clamped to +-RECON_MAX_LEVEL; nz bit k follows one cycle after level k
`timescale 1ns/100ps
`default_nettype none
`include "recon_defines.svh"

module residualQuantizer (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire pixelPkg::sbPixelsT srcBlock,
    input  wire pixelPkg::sbPixelsT predBlock,
    input  wire pixelPkg::sbIndexT  fetchIndex,
    input  wire                     fetchValid,
    input  wire quantPkg::iqStepT   iq,
    input  wire quantPkg::biasT     bias,
    input  wire quantPkg::zthreshT  zthresh,
    output pixelPkg::sbLevelsT      levels,
    output pixelPkg::sbPixelsT      predOut,
    output pixelPkg::sbIndexT       quantIndex,
    output logic                    quantValid,
    output logic                    blockNz,
    output logic [15:0]             nz
);
    import pixelPkg::*;

    localparam int SB_PIX = `RECON_SB_DIM * `RECON_SB_DIM;

    sbLevelsT          levelNext;
    logic [SB_PIX-1:0] pixelNz;

    for (genvar i = 0; i < SB_PIX; i++) begin : pixelQuant
        residualT    resid;
        logic [8:0]  mag;
        logic [32:0] scaled;
        logic [32:0] shifted;
        logic [10:0] clamped;

        assign resid   = $signed({1'b0, srcBlock[i]}) - $signed({1'b0, predBlock[i]});
        assign mag     = resid[8] ? 9'(-resid) : 9'(resid);
        assign scaled  = mag * iq + bias;
        assign shifted = scaled >> `RECON_QFIX;
        assign clamped = (shifted > 33'(`RECON_MAX_LEVEL)) ? 11'(`RECON_MAX_LEVEL)
                                                           : shifted[10:0];

        // Small residuals die at the threshold
        assign levelNext[i] = (mag <= zthresh) ? '0
                            : resid[8]        ? -levelT'({5'd0, clamped})
                                              : levelT'({5'd0, clamped});
        assign pixelNz[i] = (levelNext[i] != '0);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quantValid <= 1'b0;
            blockNz    <= 1'b0;
            nz         <= '0;
        end else begin
            quantValid <= fetchValid;
            blockNz    <= fetchValid && (|pixelNz);
            if (quantValid) begin
                nz[quantIndex] <= blockNz;
            end
        end
    end

    always_ff @(posedge clk) begin
        levels     <= levelNext;
        predOut    <= predBlock;
        quantIndex <= fetchIndex;
    end

    for (genvar i = 0; i < SB_PIX; i++) begin : levelRange
        levelBound: assert property (@(posedge clk) disable iff (!rst_n)
            quantValid |-> ($signed(levels[i]) <= `RECON_MAX_LEVEL &&
                            $signed(levels[i]) >= -`RECON_MAX_LEVEL));
    end

endmodule

`default_nettype wire

// File: quant/blockReconstructor.sv
// Dequantizes one subblock of levels, adds the prediction and clips to 0..255
// One cycle of latency
`timescale 1ns/100ps
`default_nettype none
`include "recon_defines.svh"

module blockReconstructor (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire pixelPkg::sbLevelsT levels,
    input  wire pixelPkg::sbPixelsT predOut,
    input  wire pixelPkg::sbIndexT  quantIndex,
    input  wire                     quantValid,
    input  wire quantPkg::qStepT    q,
    output pixelPkg::sbPixelsT      reconBlock,
    output pixelPkg::sbIndexT       reconIndex,
    output logic                    reconValid
);
    import pixelPkg::*;

    localparam int SB_PIX = `RECON_SB_DIM * `RECON_SB_DIM;

    sbPixelsT reconNext;

    for (genvar i = 0; i < SB_PIX; i++) begin : pixelRecon
        logic signed [33:0] sum;

        assign sum = $signed(levels[i]) * $signed({1'b0, q}) + $signed({1'b0, predOut[i]});
        assign reconNext[i] = (sum < 0)   ? 8'd0
                            : (sum > 255) ? 8'd255
                                          : pixelT'(sum[7:0]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reconValid <= 1'b0;
        end else begin
            reconValid <= quantValid;
        end
    end

    always_ff @(posedge clk) begin
        reconBlock <= reconNext;
        reconIndex <= quantIndex;
    end

endmodule

`default_nettype wire

// File: rtl/subblockStore.sv
// Writes one subblock into a 256-element image register
// raster=1 scatters into macroblock raster order, raster=0 keeps subblock order
`timescale 1ns/100ps
`default_nettype none
`include "recon_defines.svh"

module subblockStore #(
    parameter type elemT  = logic [7:0],
    parameter bit  raster = 1'b1
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     wrValid,
    input  wire pixelPkg::sbIndexT  wrIndex,
    input  wire elemT [15:0]        wrBlock,
    output elemT [`RECON_MB_DIM*`RECON_MB_DIM-1:0] image
);
    localparam int SB_PIX = `RECON_SB_DIM * `RECON_SB_DIM;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            image <= '0;
        end else if (wrValid) begin
            for (int p = 0; p < SB_PIX; p++) begin
                if (raster) begin
                    image[`RECON_RASTER_IDX(wrIndex, p)] <= wrBlock[p];
                end else begin
                    image[wrIndex * SB_PIX + p] <= wrBlock[p];
                end
            end
        end
    end

    // Index travels unreset down the pipeline
    indexKnown: assert property (@(posedge clk) disable iff (!rst_n)
        wrValid |-> (!$isunknown(wrIndex) && wrIndex < `RECON_SUBBLOCKS));

endmodule

`default_nettype wire

// File: rtl/lumaReconstruct.sv
// Luma reconstruction of one macroblock, 19 cycles from start to done
// Data and quantizer inputs must stay stable from start until done
`timescale 1ns/100ps
`default_nettype none

module lumaReconstruct (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       start,
    input  wire pixelPkg::mbPixelsT   ySrc,
    input  wire pixelPkg::mbPixelsT   yPred,
    input  wire quantPkg::qStepT      q,
    input  wire quantPkg::iqStepT     iq,
    input  wire quantPkg::biasT       bias,
    input  wire quantPkg::zthreshT    zthresh,
    output wire pixelPkg::mbPixelsT   yOut,
    output wire pixelPkg::mbLevelsT   yLevels,
    output wire logic [15:0]          nz,
    output wire logic                 done
);
    import pixelPkg::*;

    logic     stepEnable;
    logic     stepClear;
    logic     lastStep;
    logic     [4:0] step;
    sbPixelsT srcBlock;
    sbPixelsT predBlock;
    sbIndexT  fetchIndex;
    logic     fetchValid;
    sbLevelsT levels;
    sbPixelsT predOut;
    sbIndexT  quantIndex;
    logic     quantValid;
    sbPixelsT reconBlock;
    sbIndexT  reconIndex;
    logic     reconValid;

    // --------------------
    // Control
    reconSequencer uSequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .lastStep   (lastStep),
        .stepEnable (stepEnable),
        .stepClear  (stepClear),
        .done       (done)
    );

    stepCounter uCounter (
        .clk        (clk),
        .rst_n      (rst_n),
        .stepEnable (stepEnable),
        .stepClear  (stepClear),
        .step       (step),
        .lastStep   (lastStep)
    );

    // --------------------
    // Datapath, one subblock per stage
    subblockFetch uFetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .step       (step),
        .ySrc       (ySrc),
        .yPred      (yPred),
        .srcBlock   (srcBlock),
        .predBlock  (predBlock),
        .fetchIndex (fetchIndex),
        .fetchValid (fetchValid)
    );

    residualQuantizer uQuant (
        .clk        (clk),
        .rst_n      (rst_n),
        .srcBlock   (srcBlock),
        .predBlock  (predBlock),
        .fetchIndex (fetchIndex),
        .fetchValid (fetchValid),
        .iq         (iq),
        .bias       (bias),
        .zthresh    (zthresh),
        .levels     (levels),
        .predOut    (predOut),
        .quantIndex (quantIndex),
        .quantValid (quantValid),
        .blockNz    (),
        .nz         (nz)
    );

    blockReconstructor uRecon (
        .clk        (clk),
        .rst_n      (rst_n),
        .levels     (levels),
        .predOut    (predOut),
        .quantIndex (quantIndex),
        .quantValid (quantValid),
        .q          (q),
        .reconBlock (reconBlock),
        .reconIndex (reconIndex),
        .reconValid (reconValid)
    );

    // Pixels land in raster order
    subblockStore #(.elemT(pixelT), .raster(1'b1)) uPixelStore (
        .clk     (clk),
        .rst_n   (rst_n),
        .wrValid (reconValid),
        .wrIndex (reconIndex),
        .wrBlock (reconBlock),
        .image   (yOut)
    );

    // Levels stay in subblock order
    subblockStore #(.elemT(levelT), .raster(1'b0)) uLevelStore (
        .clk     (clk),
        .rst_n   (rst_n),
        .wrValid (quantValid),
        .wrIndex (quantIndex),
        .wrBlock (levels),
        .image   (yLevels)
    );

endmodule

`default_nettype wire

// File: tb/reconChecker.sv
// Reference model and scoreboard of lumaReconstruct
// Compares on the falling edge after done rises, while the inputs still hold
`timescale 1ns/100ps
`default_nettype none
`include "recon_defines.svh"

module reconChecker (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     start,
    input  wire                     done,
    input  wire pixelPkg::mbPixelsT ySrc,
    input  wire pixelPkg::mbPixelsT yPred,
    input  wire quantPkg::qStepT    q,
    input  wire quantPkg::iqStepT   iq,
    input  wire quantPkg::biasT     bias,
    input  wire quantPkg::zthreshT  zthresh,
    input  wire pixelPkg::mbPixelsT yOut,
    input  wire pixelPkg::mbLevelsT yLevels,
    input  wire [15:0]              nz,
    input  wire [127:0]             testName,
    input  wire                     checkReset,
    input  wire                     reportReq,
    output int                      testCount,
    output int                      errorCount
);
    localparam int MB         = `RECON_MB_DIM;
    localparam int SB         = `RECON_SB_DIM;
    localparam int SHOW_LIMIT = 4;

    int cycle;
    int acceptCycle;
    int testErrors;
    bit running;
    bit doneLast;

    // --------------------
    // Reference arithmetic
    function automatic int levelModel(int c, longint iqVal, longint biasVal, int thresh);
        int     m;
        longint scaled;
        m = (c < 0) ? -c : c;
        if (m <= thresh) begin
            return 0;
        end
        scaled = (longint'(m) * iqVal + biasVal) >>> `RECON_QFIX;
        if (scaled > `RECON_MAX_LEVEL) begin
            scaled = `RECON_MAX_LEVEL;
        end
        return (c < 0) ? -int'(scaled) : int'(scaled);
    endfunction

    function automatic int pixelModel(int pred, int level, int qVal);
        int sum;
        sum = pred + level * qVal;
        return (sum < 0) ? 0 : (sum > 255) ? 255 : sum;
    endfunction

    // --------------------
    // Reporting
    task automatic reportMismatch(string what, int expVal, int actVal);
        testErrors++;
        errorCount++;
        if (testErrors <= SHOW_LIMIT) begin
            $display("** Error %0s: %0s expected %0d, actual %0d",
                     testName, what, expVal, actVal);
        end
    endtask

    task automatic closeTest();
        testCount++;
        if (testErrors == 0) begin
            $display("PASS %0s", testName);
        end else begin
            $display("FAIL %0s, %0d mismatches", testName, testErrors);
        end
        testErrors = 0;
    endtask

    task automatic checkResetState();
        for (int i = 0; i < MB * MB; i++) begin
            if (yOut[i] != 0) begin
                reportMismatch($sformatf("yOut[%0d]", i), 0, int'(yOut[i]));
            end
            if (yLevels[i] != 0) begin
                reportMismatch($sformatf("yLevels[%0d]", i), 0, int'($signed(yLevels[i])));
            end
        end
        if (nz != 0) begin
            reportMismatch("nz", 0, int'(nz));
        end
        if (done) begin
            reportMismatch("done", 0, 1);
        end
        closeTest();
    endtask

    task automatic checkRun();
        int        r;
        int        idx;
        int        lvl;
        int        pix;
        bit [15:0] expNz;
        expNz = '0;
        if (cycle - acceptCycle != `RECON_RUN_STEPS) begin
            reportMismatch("done latency", `RECON_RUN_STEPS, cycle - acceptCycle);
        end
        for (int row = 0; row < MB; row++) begin
            for (int col = 0; col < MB; col++) begin
                r   = row * MB + col;
                // Levels sit in subblock order, raster inside the subblock
                idx = ((row / SB) * (MB / SB) + col / SB) * SB * SB + (row % SB) * SB + col % SB;
                lvl = levelModel(int'(ySrc[r]) - int'(yPred[r]), longint'(iq),
                                 longint'(bias), int'(zthresh));
                pix = pixelModel(int'(yPred[r]), lvl, int'(q));
                if (lvl != 0) begin
                    expNz[idx / (SB * SB)] = 1'b1;
                end
                if ($signed(yLevels[idx]) != lvl) begin
                    reportMismatch($sformatf("yLevels[%0d]", idx), lvl,
                                   int'($signed(yLevels[idx])));
                end
                if (int'(yOut[r]) != pix) begin
                    reportMismatch($sformatf("yOut[%0d]", r), pix, int'(yOut[r]));
                end
            end
        end
        for (int k = 0; k < 16; k++) begin
            if (nz[k] != expNz[k]) begin
                reportMismatch($sformatf("nz[%0d]", k), int'(expNz[k]), int'(nz[k]));
            end
        end
        closeTest();
    endtask

    // --------------------
    // Run tracking, one sample per falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            cycle      = 0;
            running    = 1'b0;
            doneLast   = 1'b0;
            testErrors = 0;
            testCount  = 0;
            errorCount = 0;
        end else begin
            cycle++;
            if (checkReset) begin
                checkResetState();
            end
            if (running && cycle == acceptCycle && done) begin
                $display("%0s: done stayed high after start was accepted", testName);
                testErrors++;
                errorCount++;
            end
            if (done && !doneLast) begin
                if (running) begin
                    checkRun();
                end else begin
                    $display("%0s: done rose with no run in progress", testName);
                    errorCount++;
                end
                running = 1'b0;
            end
            // Start seen now is taken at the next rising edge
            if (start && !running) begin
                running     = 1'b1;
                acceptCycle = cycle + 1;
            end
            doneLast = done;
            if (reportReq) begin
                $display("Summary: %0d tests checked, %0d errors", testCount, errorCount);
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_lumaReconstruct.sv
// Table-driven testbench of lumaReconstruct, 40 ns clock
// Inputs change 2 ns after the rising edge; reconChecker does all comparing
`timescale 1ns/100ps
`default_nettype none

module tb_lumaReconstruct;
    import pixelPkg::*;
    import quantPkg::*;

    localparam int PERIOD          = 40;
    localparam int DRIVE_DELAY     = 2;
    localparam int SEED            = 79343;
    localparam int NUM_TESTS       = 8;
    localparam int RUN_LIMIT       = 40;
    localparam int WATCHDOG_CYCLES = (NUM_TESTS + 2) * 30;
    localparam int MODE_RANDOM     = 0;
    localparam int MODE_FLAT       = 1;
    localparam int MODE_EXTREME    = 2;

    logic         clk;
    logic         rst_n;
    logic         start;
    mbPixelsT     ySrc;
    mbPixelsT     yPred;
    qStepT        q;
    iqStepT       iq;
    biasT         bias;
    zthreshT      zthresh;
    mbPixelsT     yOut;
    mbLevelsT     yLevels;
    logic [15:0]  nz;
    logic         done;
    logic [127:0] testName;
    logic         checkReset;
    logic         reportReq;
    int           testCount;
    int           errorCount;
    bit           timedOut;

    // Stimulus table, one row per run
    logic [127:0] rowName [NUM_TESTS];
    int           rowMode [NUM_TESTS];
    qStepT        rowQ [NUM_TESTS];
    iqStepT       rowIq [NUM_TESTS];
    biasT         rowBias [NUM_TESTS];
    zthreshT      rowZthresh [NUM_TESTS];
    bit           rowMidStart [NUM_TESTS];

    lumaReconstruct uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .ySrc    (ySrc),
        .yPred   (yPred),
        .q       (q),
        .iq      (iq),
        .bias    (bias),
        .zthresh (zthresh),
        .yOut    (yOut),
        .yLevels (yLevels),
        .nz      (nz),
        .done    (done)
    );

    reconChecker chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .done       (done),
        .ySrc       (ySrc),
        .yPred      (yPred),
        .q          (q),
        .iq         (iq),
        .bias       (bias),
        .zthresh    (zthresh),
        .yOut       (yOut),
        .yLevels    (yLevels),
        .nz         (nz),
        .testName   (testName),
        .checkReset (checkReset),
        .reportReq  (reportReq),
        .testCount  (testCount),
        .errorCount (errorCount)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("Done: errors found");
        $finish;
    end

    task automatic setRow(int idx, logic [127:0] name, int mode, qStepT qv, iqStepT iqv,
                          biasT bv, zthreshT zv, bit mid);
        rowName[idx]     = name;
        rowMode[idx]     = mode;
        rowQ[idx]        = qv;
        rowIq[idx]       = iqv;
        rowBias[idx]     = bv;
        rowZthresh[idx]  = zv;
        rowMidStart[idx] = mid;
    endtask

    task automatic fillMacroblock(int mode);
        pixelT       flatValue;
        logic [15:0] busySb;
        flatValue = pixelT'($urandom);
        busySb    = 16'($urandom);
        for (int i = 0; i < 256; i++) begin
            case (mode)
                MODE_FLAT: begin
                    ySrc[i]  = flatValue;
                    // Subblocks left clear keep a zero residual
                    yPred[i] = busySb[(i / 64) * 4 + (i % 16) / 4] ? pixelT'($urandom)
                                                                    : flatValue;
                end
                MODE_EXTREME: begin
                    ySrc[i]  = ($urandom % 2 != 0) ? 8'd255 : 8'd0;
                    yPred[i] = ($urandom % 2 != 0) ? 8'd255 : 8'd0;
                end
                default: begin
                    ySrc[i]  = pixelT'($urandom);
                    yPred[i] = pixelT'($urandom);
                end
            endcase
        end
    endtask

    task automatic pulseStart();
        start = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        start = 1'b0;
    endtask

    task automatic waitDone(logic [127:0] name);
        int waited;
        waited = 0;
        while (!done && waited < RUN_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!done) begin
            $display("%0s: done did not rise within %0d cycles", name, RUN_LIMIT);
            timedOut = 1'b1;
        end
    endtask

    task automatic runRow(int idx);
        @(posedge clk);
        #DRIVE_DELAY;
        testName = rowName[idx];
        q        = rowQ[idx];
        iq       = rowIq[idx];
        bias     = rowBias[idx];
        zthresh  = rowZthresh[idx];
        fillMacroblock(rowMode[idx]);
        pulseStart();
        // A second start in the middle of the run must be ignored
        if (rowMidStart[idx]) begin
            repeat (5) @(posedge clk);
            #DRIVE_DELAY;
            pulseStart();
        end
        waitDone(rowName[idx]);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n      = 1'b0;
        start      = 1'b0;
        ySrc       = '0;
        yPred      = '0;
        q          = '0;
        iq         = '0;
        bias       = '0;
        zthresh    = '0;
        testName   = "reset";
        checkReset = 1'b0;
        reportReq  = 1'b0;
        timedOut   = 1'b0;

        // name, source mode, q, iq, bias, zthresh, mid-run start
        setRow(0, "threshold",  MODE_RANDOM,  12,  10923,  0,            255, 1'b0);
        setRow(1, "lossless",   MODE_RANDOM,  1,   131072, 0,            0,   1'b0);
        setRow(2, "quant q20",  MODE_RANDOM,  20,  6554,   43690,        12,  1'b0);
        setRow(3, "quant q7",   MODE_RANDOM,  7,   18725,  65536,        3,   1'b0);
        setRow(4, "quant flat", MODE_FLAT,    50,  2621,   60000,        20,  1'b0);
        setRow(5, "saturation", MODE_EXTREME, 200, 262143, 32'hFFFF0000, 0,   1'b0);
        setRow(6, "sequencing", MODE_RANDOM,  9,   14564,  30000,        4,   1'b1);
        setRow(7, "rerun",      MODE_RANDOM,  3,   43691,  90000,        1,   1'b0);

        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        checkReset = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        checkReset = 1'b0;

        for (int i = 0; i < NUM_TESTS && !timedOut; i++) begin
            runRow(i);
        end

        @(posedge clk);
        #DRIVE_DELAY;
        reportReq = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        reportReq = 1'b0;

        if (testCount != NUM_TESTS + 1) begin
            $display("Checker saw %0d of %0d tests", testCount, NUM_TESTS + 1);
        end
        if (!timedOut && errorCount == 0 && testCount == NUM_TESTS + 1) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: lumaReconstruct.f
+incdir+common
common/pixelPkg.sv
common/quantPkg.sv
rtl/reconSequencer.sv
rtl/stepCounter.sv
rtl/subblockFetch.sv
quant/residualQuantizer.sv
quant/blockReconstructor.sv
rtl/subblockStore.sv
rtl/lumaReconstruct.sv
tb/reconChecker.sv
tb/tb_lumaReconstruct.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_lumaReconstruct \
		-f lumaReconstruct.f -Mdir obj_dir
	./obj_dir/Vtb_lumaReconstruct | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
